// File: src/tdm_mul_settings.svh
// width, fraction and lane count macros for the TDM multiplier
`ifndef TDM_MUL_SETTINGS_SVH
`define TDM_MUL_SETTINGS_SVH

// operand and product width W
`define TDM_WIDTH 16

// fraction bits of the fixed-point format
`define TDM_FRAC_BITS 8

// lanes sharing the multiplier
`define TDM_NUM_LANES 4

// lane index width covering TDM_NUM_LANES
`define TDM_LANE_BITS 2

`endif

// File: src/tdm_mul_pkg.sv
// data types, enums and packed structs for the TDM multiplier
`include "tdm_mul_settings.svh"

package tdm_mul_pkg;

    typedef logic [`TDM_WIDTH-1:0] data_t;
    typedef logic [2*`TDM_WIDTH-1:0] wide_t;
    typedef logic [`TDM_LANE_BITS-1:0] lane_idx_t;

    typedef enum logic {
        MODE_UNSIGNED = 1'b0,
        MODE_SIGNED   = 1'b1
    } mul_mode_e;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ISSUE = 2'd1,
        SEQ_WAIT  = 2'd2
    } seq_state_e;

    // one lane's input pair
    typedef struct packed {
        data_t mcand;
        data_t mplier;
    } lane_operand_t;

    // decoded magnitudes heading into the multiplier
    typedef struct packed {
        data_t     mcand_mag;
        data_t     mplier_mag;
        logic      negate;
        mul_mode_e mode;
        lane_idx_t lane;
    } dec_op_t;

    // full product magnitude plus what writeback needs
    typedef struct packed {
        wide_t     mag;
        logic      negate;
        mul_mode_e mode;
        lane_idx_t lane;
    } exe_res_t;

endpackage

// File: src/lane_sequencer.sv
// sweep FSM that issues lanes in order and pulses sweep_done
`include "tdm_mul_settings.svh"

module lane_sequencer (
    input  logic                  ctl_clk,
    input  logic                  ctl_rst,
    input  logic                  start,
    input  tdm_mul_pkg::mul_mode_e mode,
    input  logic                  wb_valid,
    output logic                  issue,
    output tdm_mul_pkg::lane_idx_t issue_lane,
    output tdm_mul_pkg::mul_mode_e sweep_mode,
    output logic                  sweep_done
);
    import tdm_mul_pkg::*;

    localparam lane_idx_t LAST_LANE = lane_idx_t'(`TDM_NUM_LANES - 1);

    seq_state_e state;

    // one issue pulse per visit to SEQ_ISSUE
    assign issue = (state == SEQ_ISSUE);

    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            state      <= SEQ_IDLE;
            issue_lane <= '0;
            sweep_mode <= MODE_UNSIGNED;
            sweep_done <= 1'b0;
        end else begin
            sweep_done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    // start only counts here and the mode holds for the whole sweep
                    if (start) begin
                        state      <= SEQ_ISSUE;
                        issue_lane <= '0;
                        sweep_mode <= mode;
                    end
                end
                SEQ_ISSUE: begin
                    state <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (wb_valid) begin
                        if (issue_lane == LAST_LANE) begin
                            state      <= SEQ_IDLE;
                            sweep_done <= 1'b1;
                        end else begin
                            issue_lane <= issue_lane + 1'b1;
                            state      <= SEQ_ISSUE;
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/operand_decode.sv
// lane operand select, sign strip and decode register
`include "tdm_mul_settings.svh"

module operand_decode (
    input  logic                                          ctl_clk,
    input  logic                                          ctl_rst,
    input  tdm_mul_pkg::lane_operand_t [`TDM_NUM_LANES-1:0] operands,
    input  logic                                          issue,
    input  tdm_mul_pkg::lane_idx_t                        issue_lane,
    input  tdm_mul_pkg::mul_mode_e                        sweep_mode,
    output logic                                          dec_valid,
    output tdm_mul_pkg::dec_op_t                          dec_op
);
    import tdm_mul_pkg::*;

    lane_operand_t pair;
    logic          is_signed;
    logic          a_neg;
    logic          b_neg;
    data_t         a_mag;
    data_t         b_mag;

    assign pair      = operands[issue_lane];
    assign is_signed = (sweep_mode == MODE_SIGNED);

    // sign bits only matter in signed mode
    assign a_neg = is_signed & pair.mcand[`TDM_WIDTH-1];
    assign b_neg = is_signed & pair.mplier[`TDM_WIDTH-1];

    // most negative value maps to 2^(W-1) which still fits unsigned
    assign a_mag = a_neg ? -pair.mcand : pair.mcand;
    assign b_mag = b_neg ? -pair.mplier : pair.mplier;

    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= issue;
        end
    end

    always_ff @(posedge ctl_clk) begin
        if (issue) begin
            dec_op.mcand_mag  <= a_mag;
            dec_op.mplier_mag <= b_mag;
            dec_op.negate     <= a_neg ^ b_neg;
            dec_op.mode       <= sweep_mode;
            dec_op.lane       <= issue_lane;
        end
    end

endmodule

// File: src/shift_add_mul.sv
// multi-cycle shift-and-add magnitude multiplier
`include "tdm_mul_settings.svh"

module shift_add_mul (
    input  logic                  ctl_clk,
    input  logic                  ctl_rst,
    input  logic                  dec_valid,
    input  tdm_mul_pkg::dec_op_t  dec_op,
    output logic                  exe_valid,
    output tdm_mul_pkg::exe_res_t exe_res
);
    import tdm_mul_pkg::*;

    localparam int CNT_BITS = $clog2(`TDM_WIDTH);

    logic                busy;
    logic [CNT_BITS-1:0] bit_cnt;
    wide_t               acc;
    wide_t               mcand_sh;
    data_t               mplier_sh;
    logic                negate_q;
    mul_mode_e           mode_q;
    lane_idx_t           lane_q;

    // bit 0 handled at load and bits 1..W-1 one per cycle
    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            busy      <= 1'b0;
            bit_cnt   <= '0;
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= 1'b0;
            if (dec_valid) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_BITS'(1);
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_BITS'(`TDM_WIDTH - 1)) begin
                    busy      <= 1'b0;
                    exe_valid <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge ctl_clk) begin
        if (dec_valid) begin
            acc       <= dec_op.mplier_mag[0] ? wide_t'(dec_op.mcand_mag) : '0;
            mcand_sh  <= wide_t'(dec_op.mcand_mag) << 1;
            mplier_sh <= dec_op.mplier_mag >> 1;
            negate_q  <= dec_op.negate;
            mode_q    <= dec_op.mode;
            lane_q    <= dec_op.lane;
        end else if (busy) begin
            acc       <= acc + (mplier_sh[0] ? mcand_sh : '0);
            mcand_sh  <= mcand_sh << 1;
            mplier_sh <= mplier_sh >> 1;
        end
    end

    assign exe_res = '{mag: acc, negate: negate_q, mode: mode_q, lane: lane_q};

endmodule

// File: src/product_writeback.sv
// scaling, saturation, re-signing and per-lane result registers
`include "tdm_mul_settings.svh"

module product_writeback (
    input  logic                                  ctl_clk,
    input  logic                                  ctl_rst,
    input  logic                                  exe_valid,
    input  tdm_mul_pkg::exe_res_t                 exe_res,
    output tdm_mul_pkg::data_t [`TDM_NUM_LANES-1:0] products,
    output logic [`TDM_NUM_LANES-1:0]             overflow,
    output logic                                  wb_valid
);
    import tdm_mul_pkg::*;

    localparam data_t SIGNED_MAX   = {1'b0, {(`TDM_WIDTH-1){1'b1}}};
    localparam data_t UNSIGNED_MAX = '1;

    wide_t scaled;
    logic  is_signed;
    logic  ovf;
    data_t clipped;
    data_t result;

    // truncate the fraction bits
    assign scaled    = exe_res.mag >> `TDM_FRAC_BITS;
    assign is_signed = (exe_res.mode == MODE_SIGNED);

    // signed limit 2^(W-1) and unsigned limit 2^W
    always_comb begin
        if (is_signed) begin
            ovf = |scaled[2*`TDM_WIDTH-1:`TDM_WIDTH-1];
        end else begin
            ovf = |scaled[2*`TDM_WIDTH-1:`TDM_WIDTH];
        end
    end

    always_comb begin
        if (!ovf) begin
            clipped = scaled[`TDM_WIDTH-1:0];
        end else if (is_signed) begin
            clipped = SIGNED_MAX;
        end else begin
            clipped = UNSIGNED_MAX;
        end
    end

    // sign goes back on after clipping
    assign result = exe_res.negate ? -clipped : clipped;

    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            products <= '0;
            overflow <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= exe_valid;
            if (exe_valid) begin
                products[exe_res.lane] <= result;
                overflow[exe_res.lane] <= ovf;
            end
        end
    end

endmodule

// File: src/tdm_mul.sv
// top level with sequencer, decode, execute and writeback
`include "tdm_mul_settings.svh"

module tdm_mul (
    input  logic                                          ctl_clk,
    input  logic                                          ctl_rst,
    input  logic                                          start,
    input  tdm_mul_pkg::mul_mode_e                        mode,
    input  tdm_mul_pkg::lane_operand_t [`TDM_NUM_LANES-1:0] operands,
    output tdm_mul_pkg::data_t [`TDM_NUM_LANES-1:0]         products,
    output logic [`TDM_NUM_LANES-1:0]                     overflow,
    output logic                                          sweep_done
);
    import tdm_mul_pkg::*;

    logic      issue;
    lane_idx_t issue_lane;
    mul_mode_e sweep_mode;
    logic      dec_valid;
    dec_op_t   dec_op;
    logic      exe_valid;
    exe_res_t  exe_res;
    logic      wb_valid;

    lane_sequencer seq_inst (
        .ctl_clk    (ctl_clk),
        .ctl_rst    (ctl_rst),
        .start      (start),
        .mode       (mode),
        .wb_valid   (wb_valid),
        .issue      (issue),
        .issue_lane (issue_lane),
        .sweep_mode (sweep_mode),
        .sweep_done (sweep_done)
    );

    operand_decode dec_inst (
        .ctl_clk    (ctl_clk),
        .ctl_rst    (ctl_rst),
        .operands   (operands),
        .issue      (issue),
        .issue_lane (issue_lane),
        .sweep_mode (sweep_mode),
        .dec_valid  (dec_valid),
        .dec_op     (dec_op)
    );

    shift_add_mul mul_inst (
        .ctl_clk   (ctl_clk),
        .ctl_rst   (ctl_rst),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .exe_valid (exe_valid),
        .exe_res   (exe_res)
    );

    product_writeback wb_inst (
        .ctl_clk   (ctl_clk),
        .ctl_rst   (ctl_rst),
        .exe_valid (exe_valid),
        .exe_res   (exe_res),
        .products  (products),
        .overflow  (overflow),
        .wb_valid  (wb_valid)
    );

endmodule

// File: tests/tdm_mul_tb.sv
// testbench for the TDM multiplier with stimulus table, reference model and checks
`include "tdm_mul_settings.svh"

module tdm_mul_tb;
    import tdm_mul_pkg::*;

    localparam int W            = `TDM_WIDTH;
    localparam int LANES        = `TDM_NUM_LANES;
    localparam int NUM_FIXED    = 4;
    localparam int NUM_ROWS     = 10;
    localparam int DONE_TIMEOUT = 200;

    // one row of the stimulus table with its expected values
    typedef struct packed {
        logic                      restart;
        mul_mode_e                 mode;
        lane_operand_t [LANES-1:0] ops;
        data_t [LANES-1:0]         exp_prod;
        logic [LANES-1:0]          exp_ovf;
    } row_t;

    logic                      ctl_clk;
    logic                      ctl_rst;
    logic                      start;
    mul_mode_e                 mode;
    lane_operand_t [LANES-1:0] operands;
    data_t [LANES-1:0]         products;
    logic [LANES-1:0]          overflow;
    logic                      sweep_done;

    row_t   rows [NUM_ROWS];
    string  names [NUM_ROWS];
    integer seed = 32'h010d_a0e1;
    int     mismatch_count = 0;
    int     timeout_count = 0;
    int     done_count = 0;

    tdm_mul tdm_mul_inst (
        .ctl_clk    (ctl_clk),
        .ctl_rst    (ctl_rst),
        .start      (start),
        .mode       (mode),
        .operands   (operands),
        .products   (products),
        .overflow   (overflow),
        .sweep_done (sweep_done)
    );

    initial begin
        ctl_clk = 1'b0;
        forever #10 ctl_clk = ~ctl_clk;
    end

    // every sweep_done pulse seen at a clock edge
    always @(posedge ctl_clk) begin
        if (sweep_done) begin
            done_count <= done_count + 1;
        end
    end

    // scaled magnitude clipped at the mode limit and then signed
    function automatic logic [W:0] ref_product(input mul_mode_e m, input data_t a,
                                               input data_t b);
        logic  a_neg;
        logic  b_neg;
        data_t a_mag;
        data_t b_mag;
        wide_t scaled;
        wide_t limit;
        data_t mag;
        logic  ovf;
        a_neg = (m == MODE_SIGNED) && a[W-1];
        b_neg = (m == MODE_SIGNED) && b[W-1];
        a_mag = a_neg ? data_t'(~a) + data_t'(1) : a;
        b_mag = b_neg ? data_t'(~b) + data_t'(1) : b;
        scaled = (wide_t'(a_mag) * wide_t'(b_mag)) >> `TDM_FRAC_BITS;
        limit = (m == MODE_SIGNED) ? (wide_t'(1) << (W - 1)) : (wide_t'(1) << W);
        ovf = (scaled >= limit);
        mag = ovf ? data_t'(limit - 1) : data_t'(scaled);
        if (a_neg != b_neg) begin
            mag = data_t'(~mag) + data_t'(1);
        end
        return {ovf, mag};
    endfunction

    task automatic set_row(input int idx, input string name, input logic restart,
                           input mul_mode_e m, input logic [LANES*W-1:0] mcands,
                           input logic [LANES*W-1:0] mpliers,
                           input logic [LANES*W-1:0] prods, input logic [LANES-1:0] ovfs);
        names[idx] = name;
        rows[idx].restart = restart;
        rows[idx].mode = m;
        rows[idx].exp_ovf = ovfs;
        for (int l = 0; l < LANES; l++) begin
            rows[idx].ops[l].mcand = mcands[l*W +: W];
            rows[idx].ops[l].mplier = mpliers[l*W +: W];
            rows[idx].exp_prod[l] = prods[l*W +: W];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_lanes(input string name, input int idx);
        for (int l = 0; l < LANES; l++) begin
            check_value($sformatf("%s lane %0d product", name, l),
                        rows[idx].exp_prod[l], products[l]);
            check_value($sformatf("%s lane %0d overflow", name, l),
                        rows[idx].exp_ovf[l], overflow[l]);
        end
    endtask

    task automatic wait_for_done(input string name);
        int cycles;
        cycles = 0;
        while (sweep_done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge ctl_clk);
            cycles++;
        end
        if (sweep_done !== 1'b1) begin
            $display("timeout: sweep_done did not arrive within %0d cycles in %s",
                     DONE_TIMEOUT, name);
            timeout_count++;
        end
    endtask

    initial begin
        logic [31:0]  rnd;
        data_t        a;
        data_t        b;
        logic [W:0]   res;
        int           done_before;
        ctl_rst = 1'b0;
        start = 1'b0;
        mode = MODE_UNSIGNED;
        operands = '0;

        // lane values listed as {lane3, lane2, lane1, lane0}
        set_row(0, "signed_in_range", 1'b0, MODE_SIGNED, 64'hFD00_0140_FE80_0180,
                64'hFC00_FF80_0200_0200, 64'h0C00_FF60_FD00_0300, 4'b0000);
        set_row(1, "signed_overflow", 1'b0, MODE_SIGNED, 64'h0100_4000_8000_7FFF,
                64'h0300_C000_0100_7FFF, 64'h0300_8001_8001_7FFF, 4'b0111);
        set_row(2, "unsigned_mode", 1'b0, MODE_UNSIGNED, 64'h0280_1000_FFFF_8000,
                64'h0040_1100_0100_0180, 64'h00A0_FFFF_FFFF_C000, 4'b0100);
        set_row(3, "restart_ignored", 1'b1, MODE_SIGNED, 64'hFD00_0140_FE80_0180,
                64'hFC00_FF80_0200_0200, 64'h0C00_FF60_FD00_0300, 4'b0000);

        // random rows with expected values from the reference model
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            names[r] = $sformatf("random_%0d", r);
            rows[r].restart = 1'b0;
            rnd = $random(seed);
            rows[r].mode = rnd[0] ? MODE_SIGNED : MODE_UNSIGNED;
            for (int l = 0; l < LANES; l++) begin
                rnd = $random(seed);
                a = rnd[15:0];
                b = rnd[31:16];
                // smaller multipliers on higher lanes to mix in-range and overflow
                b = $signed(b) >>> (2 * l + 2);
                rows[r].ops[l].mcand = a;
                rows[r].ops[l].mplier = b;
                res = ref_product(rows[r].mode, a, b);
                rows[r].exp_prod[l] = res[W-1:0];
                rows[r].exp_ovf[l] = res[W];
            end
        end

        repeat (10) @(posedge ctl_clk);
        ctl_rst <= 1'b1;

        // idle after reset
        repeat (20) begin
            @(negedge ctl_clk);
            check_value("idle sweep_done", 32'd0, sweep_done);
        end
        for (int l = 0; l < LANES; l++) begin
            check_value($sformatf("reset lane %0d product", l), 32'd0, products[l]);
            check_value($sformatf("reset lane %0d overflow", l), 32'd0, overflow[l]);
        end
        check_value("reset sweep_done count", 32'd0, done_count);

        for (int r = 0; r < NUM_ROWS; r++) begin
            done_before = done_count;
            @(posedge ctl_clk);
            mode <= rows[r].mode;
            operands <= rows[r].ops;
            start <= 1'b1;
            @(posedge ctl_clk);
            start <= 1'b0;
            if (rows[r].restart) begin
                // second pulse well inside the sweep carries the other mode
                repeat (30) @(posedge ctl_clk);
                mode <= (rows[r].mode == MODE_SIGNED) ? MODE_UNSIGNED : MODE_SIGNED;
                start <= 1'b1;
                @(posedge ctl_clk);
                start <= 1'b0;
            end
            wait_for_done(names[r]);
            check_lanes(names[r], r);
            repeat (20) @(negedge ctl_clk);
            check_lanes({names[r], " hold"}, r);
            check_value({names[r], " sweep_done count"}, done_before + 1, done_count);
        end

        $display("error counts: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/tdm_mul_pkg.sv
src/lane_sequencer.sv
src/operand_decode.sv
src/shift_add_mul.sv
src/product_writeback.sv
src/tdm_mul.sv
tests/tdm_mul_tb.sv

// File: run.sh
#!/bin/sh
# build and run the TDM multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tdm_mul_tb -o tdm_mul_sim

./obj_dir/tdm_mul_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
